/* common/fifo_pkg.sv */
package fifo_pkg;

  // Port widths
  localparam int wr_data_w = 8;
  localparam int rd_data_w = 32;

  // One RAM bank per byte lane of the read word
  localparam int lane_count = rd_data_w / wr_data_w;

  // Word address of each bank
  localparam int word_addr_w = 5;

  // Capacity counted in bytes
  localparam int fifo_depth = lane_count * (2 ** word_addr_w);

  // Occupancy must reach fifo_depth itself, so one bit more than the byte address
  localparam int occ_w = 8;

  typedef struct packed {
    logic [occ_w-1:0] occupancy;
    logic             full;
    logic             empty;
  } fifo_status_t;

  // Write port, a strobe with its byte
  typedef struct packed {
    logic                 en;
    logic [wr_data_w-1:0] data;
  } wr_req_t;

endpackage

/* design/ram_2p.sv */
`timescale 1ns/10ps

module ram_2p (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           w_en,
  input  logic [fifo_pkg::word_addr_w-1:0] w_addr,
  input  logic [fifo_pkg::wr_data_w-1:0]   w_data,
  input  logic                           r_en,
  input  logic [fifo_pkg::word_addr_w-1:0] r_addr,
  output logic [fifo_pkg::wr_data_w-1:0]   r_data
);

  import fifo_pkg::*;

  // One byte per word
  logic [wr_data_w-1:0] mem [2 ** word_addr_w];

  // Write port
  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[w_addr] <= w_data;
    end
  end

  // Registered read port that holds its value between reads
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      r_data <= '0;
    end else if (r_en) begin
      r_data <= mem[r_addr];
    end
  end

endmodule

/* fifo_asym/fifo_asym_w2r.sv */
`timescale 1ns/10ps

module fifo_asym_w2r (
  input  logic                          clk,
  input  logic                          rst,
  input  fifo_pkg::wr_req_t             wr,
  input  logic                          rd_en,
  output logic [fifo_pkg::rd_data_w-1:0] rd_data,
  output fifo_pkg::fifo_status_t        status
);

  import fifo_pkg::*;

  // Occupancy and flags
  logic [occ_w-1:0] occ_q;
  logic [occ_w-1:0] occ_d;
  logic             full;
  logic             empty;

  // Accepted strobes
  logic wr_acc;
  logic rd_acc;

  // Lane selector and word pointers
  logic [$clog2(lane_count)-1:0] lane_q;
  logic [lane_count-1:0]         lane_sel;
  logic                          lane_wrap;
  logic [word_addr_w-1:0]        wptr_q;
  logic [word_addr_w-1:0]        rptr_q;

  // Per-bank read bytes
  logic [wr_data_w-1:0] bank_rdata [lane_count];

  // Flags decode straight from the registered count
  assign full  = (occ_q == occ_w'(fifo_depth));
  assign empty = (occ_q < occ_w'(lane_count));

  // A write while full and a read while empty are dropped
  assign wr_acc = wr.en & ~full;
  assign rd_acc = rd_en & ~empty;

  // Next occupancy: +1 per byte in, -lane_count per word out
  always_comb begin
    occ_d = occ_q;
    if (wr_acc && !rd_acc) begin
      occ_d = occ_q + occ_w'(1);
    end else if (rd_acc && !wr_acc) begin
      occ_d = occ_q - occ_w'(lane_count);
    end else if (rd_acc && wr_acc) begin
      occ_d = occ_q - occ_w'(lane_count) + occ_w'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // Status goes out as one struct
  always_comb begin
    status.occupancy = occ_q;
    status.full      = full;
    status.empty     = empty;
  end

  // Last lane of the word is being filled
  assign lane_wrap = wr_acc && (lane_q == ($clog2(lane_count))'(lane_count - 1));

  // Lane counter steps on each accepted byte and wraps after the top lane
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane_q <= '0;
    end else if (wr_acc) begin
      lane_q <= lane_q + 1'b1;
    end
  end

  // Write word pointer moves once the word is complete
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wptr_q <= '0;
    end else if (lane_wrap) begin
      wptr_q <= wptr_q + 1'b1;
    end
  end

  // Read word pointer moves on every accepted read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rptr_q <= '0;
    end else if (rd_acc) begin
      rptr_q <= rptr_q + 1'b1;
    end
  end

  // One-hot lane select
  always_comb begin
    lane_sel         = '0;
    lane_sel[lane_q] = 1'b1;
  end

  // Bank array: writes rotate across lanes, reads hit all banks at once
  for (genvar i = 0; i < lane_count; i++) begin : g_bank
    ram_2p u_ram (
      .clk    (clk),
      .rst    (rst),
      .w_en   (wr_acc & lane_sel[i]),
      .w_addr (wptr_q),
      .w_data (wr.data),
      .r_en   (rd_acc),
      .r_addr (rptr_q),
      .r_data (bank_rdata[i])
    );

    // First byte written sits in the low lane
    assign rd_data[i*wr_data_w +: wr_data_w] = bank_rdata[i];
  end

endmodule

/* design/byte_word_fifo.sv */
`timescale 1ns/10ps

module byte_word_fifo (
  input  logic                          clk,
  input  logic                          rst,
  input  fifo_pkg::wr_req_t             wr,
  input  logic                          rd_en,
  output logic [fifo_pkg::rd_data_w-1:0] rd_data,
  output fifo_pkg::fifo_status_t        status
);

  // Byte-in, word-out FIFO core
  fifo_asym_w2r u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .status  (status)
  );

endmodule

/* sim/fifo_assertions.sv */
`timescale 1ns/10ps

module fifo_assertions (
  input logic                           clk,
  input logic                           rst,
  input fifo_pkg::wr_req_t              wr,
  input logic                           rd_en,
  input logic [fifo_pkg::rd_data_w-1:0] rd_data,
  input fifo_pkg::fifo_status_t         status
);

  import fifo_pkg::*;

  // Reference model, bytes accepted and not yet read, oldest first
  logic [wr_data_w-1:0] byte_q [$];
  logic [occ_w-1:0]     exp_occ;
  logic [rd_data_w-1:0] exp_rd_data;

  // Strobes that must leave the FIFO state alone
  logic                 empty_read_q;
  logic                 full_write_q;
  logic [occ_w-1:0]     occ_q;
  logic [rd_data_w-1:0] rd_data_q;

  // Set by any failed assertion, the testbench watches it
  logic fail_seen = 1'b0;

  always @(posedge clk or posedge rst) begin : model_update
    logic                 take_wr;
    logic                 take_rd;
    logic [rd_data_w-1:0] word;
    if (rst) begin
      byte_q.delete();
      exp_occ     <= '0;
      exp_rd_data <= '0;
    end else begin
      // Acceptance from the model's own count
      take_wr = wr.en && (byte_q.size() < fifo_depth);
      take_rd = rd_en && (byte_q.size() >= lane_count);
      if (take_rd) begin
        // Oldest byte goes to the low lane
        for (int i = 0; i < lane_count; i++) begin
          word[i*wr_data_w +: wr_data_w] = byte_q.pop_front();
        end
        exp_rd_data <= word;
      end
      if (take_wr) begin
        byte_q.push_back(wr.data);
      end
      exp_occ <= occ_w'(byte_q.size());
    end
  end

  // Values from the previous cycle for the hold checks
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      empty_read_q <= 1'b0;
      full_write_q <= 1'b0;
      occ_q        <= '0;
      rd_data_q    <= '0;
    end else begin
      empty_read_q <= rd_en && status.empty && !wr.en;
      full_write_q <= wr.en && status.full && !rd_en;
      occ_q        <= status.occupancy;
      rd_data_q    <= rd_data;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    (rst || $past(rst)) |->
      (status.occupancy == '0 && status.empty && !status.full && rd_data == '0))
  else begin
    fail_seen = 1'b1;
    $error("Mismatch reset state: occupancy %h empty %h full %h rd_data %h, expected 00 1 0 0",
           $sampled(status.occupancy), $sampled(status.empty), $sampled(status.full),
           $sampled(rd_data));
  end

  a_occupancy: assert property (@(posedge clk) disable iff (rst)
    status.occupancy == exp_occ)
  else begin
    fail_seen = 1'b1;
    $error("Mismatch status.occupancy expected %h actual %h",
           $sampled(exp_occ), $sampled(status.occupancy));
  end

  a_empty_flag: assert property (@(posedge clk) disable iff (rst)
    status.empty == (exp_occ < occ_w'(lane_count)))
  else begin
    fail_seen = 1'b1;
    $error("Mismatch status.empty expected %h actual %h",
           $sampled(exp_occ < occ_w'(lane_count)), $sampled(status.empty));
  end

  a_full_flag: assert property (@(posedge clk) disable iff (rst)
    status.full == (exp_occ == occ_w'(fifo_depth)))
  else begin
    fail_seen = 1'b1;
    $error("Mismatch status.full expected %h actual %h",
           $sampled(exp_occ == occ_w'(fifo_depth)), $sampled(status.full));
  end

  a_word_order: assert property (@(posedge clk) disable iff (rst)
    rd_data == exp_rd_data)
  else begin
    fail_seen = 1'b1;
    $error("Mismatch rd_data expected %h actual %h", $sampled(exp_rd_data), $sampled(rd_data));
  end

  // Read while empty changes nothing
  a_empty_read: assert property (@(posedge clk) disable iff (rst)
    empty_read_q |-> (rd_data == rd_data_q && status.occupancy == occ_q))
  else begin
    fail_seen = 1'b1;
    $error("Mismatch rd_data expected %h actual %h, occupancy expected %h actual %h",
           $sampled(rd_data_q), $sampled(rd_data), $sampled(occ_q),
           $sampled(status.occupancy));
  end

  // Write while full is dropped
  a_full_write: assert property (@(posedge clk) disable iff (rst)
    full_write_q |-> (status.occupancy == occ_q && status.full))
  else begin
    fail_seen = 1'b1;
    $error("Mismatch status.occupancy expected %h actual %h after a write while full",
           $sampled(occ_q), $sampled(status.occupancy));
  end

endmodule

bind byte_word_fifo fifo_assertions u_chk (
  .clk     (clk),
  .rst     (rst),
  .wr      (wr),
  .rd_en   (rd_en),
  .rd_data (rd_data),
  .status  (status)
);

/* sim/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  localparam int half_period_ns = 2;
  localparam int reset_cycles   = 10;

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // Clean rising edge on rst, then release after the reset cycles
  initial begin
    rst = 1'b0;
    #1 rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* sim/tb_byte_word_fifo.sv */
`timescale 1ns/10ps

module tb_byte_word_fifo;

  import fifo_pkg::*;

  // Cycle budget of each phase
  localparam int reset_cycles  = 12;
  localparam int basic_cycles  = 8 + 1 + 10;
  localparam int full_writes   = 140;
  localparam int full_cycles   = full_writes + 1 + fifo_depth / lane_count + 10;
  localparam int empty_cycles  = 3 + 1 + 2 + 2;
  localparam int rand_cycles   = 2000;
  localparam int drain_cycles  = fifo_depth / lane_count + 10;
  localparam int margin_cycles = 200;
  localparam int clk_period_ns = 4;
  localparam int timeout_ns    = (reset_cycles + basic_cycles + full_cycles + empty_cycles +
                                  rand_cycles + drain_cycles + margin_cycles) * clk_period_ns;

  logic                 clk;
  logic                 rst;
  wr_req_t              wr;
  logic                 rd_en;
  logic [rd_data_w-1:0] rd_data;
  fifo_status_t         status;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  byte_word_fifo u_dut (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .status  (status)
  );

  task automatic write_byte(input logic [wr_data_w-1:0] b);
    @(posedge clk);
    wr    <= '{en: 1'b1, data: b};
    rd_en <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      wr.en <= 1'b0;
      rd_en <= 1'b0;
    end
  endtask

  // Hold rd_en until the FIFO reports empty
  task automatic read_until_empty();
    @(posedge clk);
    wr.en <= 1'b0;
    rd_en <= 1'b1;
    @(negedge clk);
    while (!status.empty) @(negedge clk);
    @(posedge clk);
    rd_en <= 1'b0;
  endtask

  task automatic read_strobes(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      wr.en <= 1'b0;
      rd_en <= 1'b1;
    end
    @(posedge clk);
    rd_en <= 1'b0;
  endtask

  // Mixed traffic, fill and drain bias swap every 500 cycles
  task automatic run_random(input int cycles);
    int unsigned roll_w;
    int unsigned roll_r;
    int unsigned w_cut;
    int unsigned r_cut;
    for (int i = 0; i < cycles; i++) begin
      if (((i / 500) % 2) == 0) begin
        w_cut = 7;
        r_cut = 1;
      end else begin
        w_cut = 3;
        r_cut = 3;
      end
      roll_w = $urandom % 8;
      roll_r = $urandom % 8;
      @(posedge clk);
      wr    <= '{en: (roll_w < w_cut), data: 8'($urandom)};
      rd_en <= (roll_r < r_cut);
    end
    @(posedge clk);
    wr.en <= 1'b0;
    rd_en <= 1'b0;
  endtask

  // Stop at the first failed assertion
  always @(negedge clk) begin
    if (u_dut.u_chk.fail_seen) begin
      $display("Checks failed");
      $fatal(1, "An assertion in the bound checker failed");
    end
  end

  initial begin
    #(timeout_ns);
    $display("Checks failed");
    $fatal(1, "Timeout after %0d ns, the stimulus did not finish", timeout_ns);
  end

  initial begin
    int unsigned seed_ack;
    wr       = '0;
    rd_en    = 1'b0;
    seed_ack = $urandom(32'h10e7_5982);
    @(negedge rst);
    @(posedge clk);

    // Known bytes, two words back
    for (int i = 0; i < 8; i++) begin
      write_byte(8'(i + 16));
    end
    idle_cycles(1);
    read_until_empty();

    // Overfill, then drain the first 128 bytes
    for (int i = 0; i < full_writes; i++) begin
      write_byte(8'($urandom));
    end
    idle_cycles(1);
    read_until_empty();

    // Partial word only, reads are ignored
    for (int i = 0; i < 3; i++) begin
      write_byte(8'($urandom));
    end
    idle_cycles(1);
    read_strobes(2);
    idle_cycles(2);

    run_random(rand_cycles);
    read_until_empty();
    idle_cycles(2);

    @(negedge clk);
    if (u_dut.u_chk.fail_seen) begin
      $display("Checks failed");
      $fatal(1, "An assertion failed during the run");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

/* byte_word_fifo.f */
common/fifo_pkg.sv
design/ram_2p.sv
fifo_asym/fifo_asym_w2r.sv
design/byte_word_fifo.sv
sim/fifo_assertions.sv
sim/tb_clk_gen.sv
sim/tb_byte_word_fifo.sv

/* run.sh */
#!/bin/sh
# Build and run the byte_word_fifo testbench with Verilator.
# Exit status is 0 only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_byte_word_fifo \
  -Mdir obj_dir \
  -f byte_word_fifo.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let the testbench see a failed assertion before the simulator stops on it
out=$(./obj_dir/Vtb_byte_word_fifo +verilator+error+limit+100 2>&1)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
